//--- bootrom/boot_rom.sv
`timescale 1ns/1ps

module boot_rom import periph_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              boot_sel_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o
);

  logic [2:0]        word_idx;
  logic              valid_q;
  logic [DATA_W-1:0] rdata_q;

  // 64-bit words, byte offset dropped
  assign word_idx = addr_i[5:3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i;
    end
  end

  // boot_sel_i high picks the bare-metal image
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= boot_sel_i ? ROM_BM_IMAGE[word_idx] : ROM_LINUX_IMAGE[word_idx];
    end
  end

  assign rvalid_o = valid_q;
  assign rdata_o  = rdata_q;

endmodule

//--- clint/clint_regs.sv
`timescale 1ns/1ps

module clint_regs import periph_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic              rtc_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  logic [ADDR_W-1:0] off;
  logic              wr;
  logic [2:0]        rtc_q;
  logic              rtc_rise;
  logic              msip_q;
  logic [DATA_W-1:0] mtimecmp_q;
  logic [DATA_W-1:0] mtime_q;
  logic              valid_q;
  logic [DATA_W-1:0] rdata_q;

  assign off = addr_i - CLINT_BASE;
  assign wr  = req_i & we_i;

  // two sync stages, third stage for the edge
  assign rtc_rise = rtc_q[1] & ~rtc_q[2];

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q      <= '0;
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
      valid_q    <= 1'b0;
    end else begin
      rtc_q   <= {rtc_q[1:0], rtc_i};
      valid_q <= req_i;
      if (wr && off == CLINT_MSIP_OFF) begin
        msip_q <= wdata_i[0];
      end
      if (wr && off == CLINT_MTIMECMP_OFF) begin
        mtimecmp_q <= wdata_i;
      end
      // software write wins over a tick
      if (wr && off == CLINT_MTIME_OFF) begin
        mtime_q <= wdata_i;
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + DATA_W'(1);
      end
    end
  end

  // read data
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      unique case (off)
        CLINT_MSIP_OFF:     rdata_q <= DATA_W'(msip_q);
        CLINT_MTIMECMP_OFF: rdata_q <= mtimecmp_q;
        CLINT_MTIME_OFF:    rdata_q <= mtime_q;
        default:            rdata_q <= '0;
      endcase
    end
  end

  assign rvalid_o = valid_q;
  assign rdata_o  = rdata_q;

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

//--- common/periph_pkg.sv
package periph_pkg;

  //////////////////////////////////////////////////
  // bus and register widths
  //////////////////////////////////////////////////

  localparam int unsigned ADDR_W  = 40;
  localparam int unsigned DATA_W  = 64;
  localparam int unsigned REG_W   = 32;
  localparam int unsigned NUM_SRC = 8;

  // address map of the three targets
  localparam logic [ADDR_W-1:0] ROM_BASE   = 40'hfff1010000;
  localparam logic [ADDR_W-1:0] CLINT_BASE = 40'hfff1020000;
  localparam logic [ADDR_W-1:0] PLIC_BASE  = 40'hfff1100000;
  localparam logic [ADDR_W-1:0] ROM_SIZE   = 40'h0000010000;
  localparam logic [ADDR_W-1:0] CLINT_SIZE = 40'h00000c0000;
  localparam logic [ADDR_W-1:0] PLIC_SIZE  = 40'h0004000000;

  // clint register offsets from CLINT_BASE
  localparam logic [ADDR_W-1:0] CLINT_MSIP_OFF     = 40'h0;
  localparam logic [ADDR_W-1:0] CLINT_MTIMECMP_OFF = 40'h4000;
  localparam logic [ADDR_W-1:0] CLINT_MTIME_OFF    = 40'hbff8;

  // plic register offsets from PLIC_BASE
  localparam logic [REG_W-1:0] PLIC_PENDING_OFF = 32'h0;
  localparam logic [REG_W-1:0] PLIC_ENABLE_OFF  = 32'h4;
  localparam logic [REG_W-1:0] PLIC_CLAIM_OFF   = 32'h8;

  //////////////////////////////////////////////////
  // boot images
  //////////////////////////////////////////////////

  localparam int unsigned ROM_WORDS = 8;

  // bare-metal image
  localparam logic [DATA_W-1:0] ROM_BM_IMAGE [ROM_WORDS] = '{
    64'h0010041b_f1402573, 64'h00000597_01f41413, 64'h00008402_0f058593,
    64'h0000006f_10500073, 64'h5a5a0001_00000000, 64'h5a5a0002_00000000,
    64'h5a5a0003_00000000, 64'h5a5a0004_00000000
  };

  // linux image, jumps to the kernel after the device tree pointer setup
  localparam logic [DATA_W-1:0] ROM_LINUX_IMAGE [ROM_WORDS] = '{
    64'h8000041b_f1402573, 64'h00000597_01f41413, 64'h00008402_04058593,
    64'h0000006f_10500073, 64'hd00dfeed_00000000, 64'hc0de0001_00000000,
    64'hc0de0002_00000000, 64'hc0de0003_00000000
  };

  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_ROM,
    TGT_CLINT,
    TGT_PLIC
  } target_e;

endpackage

//--- hdl/periph_decode.sv
`timescale 1ns/1ps

module periph_decode import periph_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              plic_busy_i,
  input  logic              rom_valid_i,
  input  logic [DATA_W-1:0] rom_rdata_i,
  input  logic              clint_valid_i,
  input  logic [DATA_W-1:0] clint_rdata_i,
  input  logic              plic_valid_i,
  input  logic [DATA_W-1:0] plic_rdata_i,
  output logic              gnt_o,
  output logic              rom_req_o,
  output logic              clint_req_o,
  output logic              plic_req_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o
);

  target_e tgt;
  logic    accept;
  logic    none_q;

  // region match
  always_comb begin
    tgt = TGT_NONE;
    if (addr_i >= ROM_BASE && addr_i < ROM_BASE + ROM_SIZE) begin
      tgt = TGT_ROM;
    end else if (addr_i >= CLINT_BASE && addr_i < CLINT_BASE + CLINT_SIZE) begin
      tgt = TGT_CLINT;
    end else if (addr_i >= PLIC_BASE && addr_i < PLIC_BASE + PLIC_SIZE) begin
      tgt = TGT_PLIC;
    end
  end

  // only the plic adapter can stall the bus
  assign gnt_o  = ~plic_busy_i;
  assign accept = req_i & gnt_o;

  assign rom_req_o   = accept && (tgt == TGT_ROM);
  assign clint_req_o = accept && (tgt == TGT_CLINT);
  assign plic_req_o  = accept && (tgt == TGT_PLIC);

  // unmapped access still owes one response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      none_q <= 1'b0;
    end else begin
      none_q <= accept && (tgt == TGT_NONE);
    end
  end

  assign rvalid_o = rom_valid_i | clint_valid_i | plic_valid_i | none_q;

  // unmapped reads fall through to zero
  always_comb begin
    rdata_o = '0;
    if (rom_valid_i) begin
      rdata_o = rom_rdata_i;
    end else if (clint_valid_i) begin
      rdata_o = clint_rdata_i;
    end else if (plic_valid_i) begin
      rdata_o = plic_rdata_i;
    end
  end

endmodule

//--- hdl/periph_top.sv
`timescale 1ns/1ps

module periph_top import periph_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               we_i,
  input  logic               wide_i,
  input  logic [ADDR_W-1:0]  addr_i,
  input  logic [DATA_W-1:0]  wdata_i,
  input  logic               boot_sel_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output logic [DATA_W-1:0]  rdata_o,
  input  logic               rtc_i,
  input  logic [NUM_SRC-1:0] irq_src_i,
  output logic               timer_irq_o,
  output logic               ipi_o,
  output logic               irq_o
);

  logic              rom_req, clint_req, plic_req;
  logic              rom_valid, clint_valid, plic_valid;
  logic [DATA_W-1:0] rom_rdata, clint_rdata, plic_rdata;
  logic              plic_busy;

  // adapter to plic core
  logic             reg_req, reg_we;
  logic [REG_W-1:0] reg_addr, reg_wdata, reg_rdata;

  periph_decode u_periph_decode (
    .clk_i, .rst_ni, .req_i, .addr_i,
    .plic_busy_i   (plic_busy),
    .rom_valid_i   (rom_valid),   .rom_rdata_i   (rom_rdata),
    .clint_valid_i (clint_valid), .clint_rdata_i (clint_rdata),
    .plic_valid_i  (plic_valid),  .plic_rdata_i  (plic_rdata),
    .gnt_o, .rom_req_o (rom_req), .clint_req_o (clint_req), .plic_req_o (plic_req),
    .rvalid_o, .rdata_o
  );

  boot_rom u_boot_rom (
    .clk_i, .rst_ni, .req_i (rom_req), .addr_i, .boot_sel_i,
    .rvalid_o (rom_valid), .rdata_o (rom_rdata)
  );

  clint_regs u_clint_regs (
    .clk_i, .rst_ni, .req_i (clint_req), .we_i, .addr_i, .wdata_i, .rtc_i,
    .rvalid_o (clint_valid), .rdata_o (clint_rdata), .timer_irq_o, .ipi_o
  );

  plic_split_adapter u_plic_split_adapter (
    .clk_i, .rst_ni, .req_i (plic_req), .we_i, .wide_i, .addr_i, .wdata_i,
    .reg_rdata_i (reg_rdata), .busy_o (plic_busy),
    .rvalid_o (plic_valid), .rdata_o (plic_rdata),
    .reg_req_o (reg_req), .reg_we_o (reg_we), .reg_addr_o (reg_addr),
    .reg_wdata_o (reg_wdata)
  );

  plic_core u_plic_core (
    .clk_i, .rst_ni, .reg_req_i (reg_req), .reg_we_i (reg_we),
    .reg_addr_i (reg_addr), .reg_wdata_i (reg_wdata), .reg_rdata_o (reg_rdata),
    .irq_src_i, .irq_o
  );

endmodule

//--- plic/plic_core.sv
`timescale 1ns/1ps

module plic_core import periph_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               reg_req_i,
  input  logic               reg_we_i,
  input  logic [REG_W-1:0]   reg_addr_i,
  input  logic [REG_W-1:0]   reg_wdata_i,
  output logic [REG_W-1:0]   reg_rdata_o,
  input  logic [NUM_SRC-1:0] irq_src_i,
  output logic               irq_o
);

  logic [NUM_SRC-1:0] src_q, src_qq;
  logic [NUM_SRC-1:0] pending_q, enable_q;
  logic [NUM_SRC-1:0] active;
  logic [NUM_SRC-1:0] claim_mask;
  logic [REG_W-1:0]   claim_id;
  logic               claim_rd;

  assign active = pending_q & enable_q;

  // lowest index wins, loop runs downwards so the last hit is kept
  always_comb begin
    claim_id   = '0;
    claim_mask = '0;
    for (int i = NUM_SRC - 1; i >= 0; i--) begin
      if (active[i]) begin
        claim_id   = REG_W'(i + 1);
        claim_mask = NUM_SRC'(1) << i;
      end
    end
  end

  assign claim_rd = reg_req_i && !reg_we_i && (reg_addr_i == PLIC_CLAIM_OFF);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q     <= '0;
      src_qq    <= '0;
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      src_q  <= irq_src_i;
      src_qq <= src_q;
      // a new edge re-arms a source claimed in the same cycle
      pending_q <= (pending_q & ~(claim_rd ? claim_mask : '0)) | (src_q & ~src_qq);
      if (reg_req_i && reg_we_i && reg_addr_i == PLIC_ENABLE_OFF) begin
        enable_q <= reg_wdata_i[NUM_SRC-1:0];
      end
    end
  end

  always_comb begin
    unique case (reg_addr_i)
      PLIC_PENDING_OFF: reg_rdata_o = REG_W'(pending_q);
      PLIC_ENABLE_OFF:  reg_rdata_o = REG_W'(enable_q);
      PLIC_CLAIM_OFF:   reg_rdata_o = claim_id;
      default:          reg_rdata_o = '0;
    endcase
  end

  assign irq_o = |active;

endmodule

//--- plic/plic_split_adapter.sv
`timescale 1ns/1ps

module plic_split_adapter import periph_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              we_i,
  input  logic              wide_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [REG_W-1:0]  reg_rdata_i,
  output logic              busy_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              reg_req_o,
  output logic              reg_we_o,
  output logic [REG_W-1:0]  reg_addr_o,
  output logic [REG_W-1:0]  reg_wdata_o
);

  typedef enum logic [1:0] {Idle, Second, Resp} state_e;

  state_e           state_d, state_q;
  logic [REG_W-1:0] off_in;
  logic             accept;
  logic [REG_W-1:0] off_q, whi_q;
  logic             we_q;
  logic [REG_W-1:0] lo_d, lo_q, hi_d, hi_q;

  // base-relative offset, truncated to the register width
  assign off_in = addr_i[REG_W-1:0] - PLIC_BASE[REG_W-1:0];

  // a new access can start in the response cycle
  assign accept = req_i && (state_q != Second);

  always_comb begin
    state_d     = state_q;
    reg_req_o   = 1'b0;
    reg_we_o    = we_i;
    reg_addr_o  = off_in;
    reg_wdata_o = wdata_i[REG_W-1:0];
    lo_d        = lo_q;
    hi_d        = hi_q;
    case (state_q)
      // high word at offset plus 4
      Second: begin
        reg_req_o   = 1'b1;
        reg_we_o    = we_q;
        reg_addr_o  = off_q + REG_W'(REG_W / 8);
        reg_wdata_o = whi_q;
        hi_d        = reg_rdata_i;
        state_d     = Resp;
      end
      default: begin
        state_d = Idle;
        if (req_i) begin
          reg_req_o = 1'b1;
          lo_d      = reg_rdata_i;
          hi_d      = '0;
          state_d   = wide_i ? Second : Resp;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // second half of a wide access and the read words
  always_ff @(posedge clk_i) begin
    if (accept) begin
      off_q <= off_in;
      whi_q <= wdata_i[DATA_W-1:REG_W];
      we_q  <= we_i;
    end
    lo_q <= lo_d;
    hi_q <= hi_d;
  end

  assign busy_o   = (state_q == Second);
  assign rvalid_o = (state_q == Resp);
  assign rdata_o  = {hi_q, lo_q};

endmodule

//--- verification/tb_periph.sv
`timescale 1ns/1ps

module tb_periph import periph_pkg::*; ();

  localparam int TIMEOUT = 20;

  typedef enum logic [1:0] {OP_RD, OP_WR, OP_RTC, OP_SRC} op_e;

  // one row of the stimulus table, exp_irq is {timer, ipi, irq}
  typedef struct packed {
    op_e                op;
    logic [ADDR_W-1:0]  addr;
    logic               wide;
    logic [DATA_W-1:0]  wdata;
    logic               boot_sel;
    logic [NUM_SRC-1:0] src;
    logic [DATA_W-1:0]  exp_rdata;
    logic [1:0]         exp_lat;
    logic [2:0]         exp_irq;
  } step_t;

  logic clk_i, rst_ni, req_i, we_i, wide_i, boot_sel_i, rtc_i;
  logic [ADDR_W-1:0]  addr_i;
  logic [DATA_W-1:0]  wdata_i, rdata_o;
  logic [NUM_SRC-1:0] irq_src_i;
  logic gnt_o, rvalid_o, timer_irq_o, ipi_o, irq_o;

  step_t steps[$];
  int    errors = 0;
  int    timeouts = 0;

  periph_top u_periph_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic void add_step(op_e op, logic [ADDR_W-1:0] addr, logic wide,
                                   logic [DATA_W-1:0] wdata, logic boot_sel,
                                   logic [NUM_SRC-1:0] src, logic [DATA_W-1:0] exp_rdata,
                                   logic [1:0] exp_lat, logic [2:0] exp_irq);
    step_t s;
    s = '{op, addr, wide, wdata, boot_sel, src, exp_rdata, exp_lat, exp_irq};
    steps.push_back(s);
  endfunction

  task automatic wait_cycle();
    @(posedge clk_i);
    #1;
  endtask

  //////////////////////////////////////////////////
  // one bus access, gnt and rvalid waits bounded
  //////////////////////////////////////////////////

  task automatic bus_access(input int idx, input step_t s);
    int waited;
    int lat;
    int gnt_low;
    req_i      = 1'b1;
    we_i       = (s.op == OP_WR);
    wide_i     = s.wide;
    addr_i     = s.addr;
    wdata_i    = s.wdata;
    boot_sel_i = s.boot_sel;
    waited     = 0;
    while (!gnt_o && waited < TIMEOUT) begin
      wait_cycle();
      waited++;
    end
    assert (gnt_o) else begin
      timeouts++;
      $display("step %0d: gnt_o never came high", idx);
    end
    // acceptance edge
    wait_cycle();
    req_i   = 1'b0;
    we_i    = 1'b0;
    lat     = 1;
    gnt_low = 0;
    while (!rvalid_o && lat < TIMEOUT) begin
      if (!gnt_o) gnt_low++;
      wait_cycle();
      lat++;
    end
    assert (rvalid_o) else begin
      timeouts++;
      $display("step %0d: no response arrived on rvalid_o", idx);
    end
    if (rvalid_o) begin
      assert (lat == int'(s.exp_lat) && gnt_low == int'(s.exp_lat) - 1) else begin
        errors++;
        $display("Fail at %0t: step %0d latency %0d gnt low %0d, expected latency %0d",
                 $time, idx, lat, gnt_low, s.exp_lat);
      end
      if (s.op == OP_RD) begin
        assert (rdata_o == s.exp_rdata) else begin
          errors++;
          $display("Fail at %0t: step %0d read %h, expected %h",
                   $time, idx, rdata_o, s.exp_rdata);
        end
      end
      wait_cycle();
      assert (!rvalid_o) else begin
        errors++;
        $display("Fail at %0t: step %0d rvalid_o held longer than one cycle", $time, idx);
      end
    end
  endtask

  task automatic run_step(input int idx, input step_t s);
    case (s.op)
      // each rtc phase spans the sync flops
      OP_RTC: begin
        repeat (int'(s.wdata)) begin
          rtc_i = 1'b1;
          repeat (4) wait_cycle();
          rtc_i = 1'b0;
          repeat (4) wait_cycle();
        end
      end
      OP_SRC: begin
        irq_src_i = s.src;
        wait_cycle();
        irq_src_i = '0;
        repeat (3) wait_cycle();
      end
      default: bus_access(idx, s);
    endcase
    assert ({timer_irq_o, ipi_o, irq_o} == s.exp_irq) else begin
      errors++;
      $display("Fail at %0t: step %0d irq outputs %b, expected %b",
               $time, idx, {timer_irq_o, ipi_o, irq_o}, s.exp_irq);
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus table and main loop
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]       rng;
    logic [DATA_W-1:0] r_cmp;
    logic [DATA_W-1:0] r_low;
    rst_ni = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    wide_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    boot_sel_i = 1'b0;
    rtc_i = 1'b0;
    irq_src_i = '0;
    rng = 32'h1d391d94;
    rng = xorshift(rng);
    r_cmp[63:32] = rng;
    rng = xorshift(rng);
    r_cmp[31:0] = rng;
    rng = xorshift(rng);
    r_low = {32'h0, rng};

    for (int i = 0; i < ROM_WORDS; i++) begin
      add_step(OP_RD, ROM_BASE + 8 * i, 1, '0, 1, '0, ROM_BM_IMAGE[i], 1, 3'b000);
    end
    for (int i = 0; i < ROM_WORDS; i++) begin
      add_step(OP_RD, ROM_BASE + 8 * i, 1, '0, 0, '0, ROM_LINUX_IMAGE[i], 1, 3'b000);
    end
    add_step(OP_WR, CLINT_BASE + CLINT_MTIMECMP_OFF, 1, r_cmp, 0, '0, '0, 1, 3'b000);
    add_step(OP_RD, CLINT_BASE + CLINT_MTIMECMP_OFF, 1, '0, 0, '0, r_cmp, 1, 3'b000);
    add_step(OP_WR, CLINT_BASE + CLINT_MSIP_OFF, 1, 64'h1, 0, '0, '0, 1, 3'b010);
    add_step(OP_RD, CLINT_BASE + CLINT_MSIP_OFF, 1, '0, 0, '0, 64'h1, 1, 3'b010);
    add_step(OP_WR, CLINT_BASE + CLINT_MSIP_OFF, 1, 64'h0, 0, '0, '0, 1, 3'b000);
    add_step(OP_WR, CLINT_BASE + CLINT_MTIME_OFF, 1, r_cmp, 0, '0, '0, 1, 3'b100);
    add_step(OP_RD, CLINT_BASE + CLINT_MTIME_OFF, 1, '0, 0, '0, r_cmp, 1, 3'b100);
    add_step(OP_WR, CLINT_BASE + CLINT_MTIMECMP_OFF, 1, '1, 0, '0, '0, 1, 3'b000);
    add_step(OP_WR, CLINT_BASE + CLINT_MTIME_OFF, 1, '0, 0, '0, '0, 1, 3'b000);
    add_step(OP_RTC, '0, 0, 64'd5, 0, '0, '0, 0, 3'b000);
    add_step(OP_RD, CLINT_BASE + CLINT_MTIME_OFF, 1, '0, 0, '0, 64'd5, 1, 3'b000);
    // wide write lands its high word in the enable register
    add_step(OP_WR, PLIC_BASE, 1, {32'hb5, r_low[31:0]}, 0, '0, '0, 2, 3'b000);
    add_step(OP_RD, PLIC_BASE + 4, 0, '0, 0, '0, 64'hb5, 1, 3'b000);
    add_step(OP_RD, PLIC_BASE, 0, '0, 0, '0, 64'h0, 1, 3'b000);
    add_step(OP_RD, PLIC_BASE, 1, '0, 0, '0, {32'hb5, 32'h0}, 2, 3'b000);
    // sources 1,2,3,5 fire, only 2 and 5 are enabled
    add_step(OP_SRC, '0, 0, '0, 0, 8'h2e, '0, 0, 3'b001);
    add_step(OP_RD, PLIC_BASE, 0, '0, 0, '0, 64'h2e, 1, 3'b001);
    add_step(OP_RD, 40'h0080000000, 1, '0, 0, '0, 64'h0, 1, 3'b001);
    add_step(OP_RD, PLIC_BASE + 8, 0, '0, 0, '0, 64'd3, 1, 3'b001);
    add_step(OP_RD, PLIC_BASE + 8, 0, '0, 0, '0, 64'd6, 1, 3'b000);
    add_step(OP_RD, PLIC_BASE + 8, 0, '0, 0, '0, 64'd0, 1, 3'b000);
    add_step(OP_RD, 40'hfff1000000, 1, '0, 0, '0, 64'h0, 1, 3'b000);
    add_step(OP_WR, 40'hfff1000000, 1, r_cmp, 0, '0, '0, 1, 3'b000);

    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    wait_cycle();
    for (int i = 0; i < steps.size(); i++) begin
      run_step(i, steps[i]);
    end

    $display("value errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
common/periph_pkg.sv
hdl/periph_decode.sv
bootrom/boot_rom.sv
clint/clint_regs.sv
plic/plic_split_adapter.sv
plic/plic_core.sv
hdl/periph_top.sv
verification/tb_periph.sv
